/* hdl/pid_pkg.sv */
`default_nettype none

package pid_pkg;

    // Datapath widths
    localparam int input_width = 12;
    localparam int data_width = 16;
    localparam int product_width = 2 * data_width;
    // One guard bit for sums of two data words
    localparam int sum_width = data_width + 1;

    // Configuration bus widths
    localparam int cfg_addr_width = 3;
    localparam int cfg_word_width = 32;
    localparam int shift_width = 8;
    localparam int cfg_word_count = 2 ** cfg_addr_width;

    // Register map
    localparam logic [cfg_addr_width-1:0] cfg_addr_control = 3'd0;
    localparam logic [cfg_addr_width-1:0] cfg_addr_kp = 3'd1;
    localparam logic [cfg_addr_width-1:0] cfg_addr_ki = 3'd2;
    localparam logic [cfg_addr_width-1:0] cfg_addr_out_up = 3'd3;
    localparam logic [cfg_addr_width-1:0] cfg_addr_out_down = 3'd4;
    localparam logic [cfg_addr_width-1:0] cfg_addr_int_up = 3'd5;
    localparam logic [cfg_addr_width-1:0] cfg_addr_int_down = 3'd6;
    localparam logic [cfg_addr_width-1:0] cfg_addr_shifts = 3'd7;

    // Bit position of the free-running flag in the control word
    localparam int control_free_running_bit = 0;

    // Reset contents of the register bank
    localparam logic [cfg_word_width-1:0] reset_control = 32'h0000_0000;
    localparam logic [cfg_word_width-1:0] reset_gain = 32'h0000_0000;
    localparam logic [cfg_word_width-1:0] reset_limit_up = 32'h0000_7fff;
    // -32767 sign-extended to the full word
    localparam logic [cfg_word_width-1:0] reset_limit_down = 32'hffff_8001;
    localparam logic [cfg_word_width-1:0] reset_shifts = 32'h0000_0101;

    localparam logic [cfg_word_width-1:0] cfg_reset_values [cfg_word_count] = '{
        reset_control,
        reset_gain,
        reset_gain,
        reset_limit_up,
        reset_limit_down,
        reset_limit_up,
        reset_limit_down,
        reset_shifts
    };

    // A configuration word, either taken whole or split into the two shift fields
    typedef union packed {
        logic [cfg_word_width-1:0] raw;
        struct packed {
            logic [cfg_word_width-2*shift_width-1:0] reserved;
            logic [shift_width-1:0] ki_shift;
            logic [shift_width-1:0] kp_shift;
        } shifts;
    } pid_cfg_word_u;

endpackage

`default_nettype wire

/* hdl/pid_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_config_regs (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic cfg_write,
    input  wire logic [pid_pkg::cfg_addr_width-1:0] cfg_write_addr,
    input  wire logic [pid_pkg::cfg_word_width-1:0] cfg_write_data,
    input  wire logic cfg_read,
    input  wire logic [pid_pkg::cfg_addr_width-1:0] cfg_read_addr,
    output logic [pid_pkg::cfg_word_width-1:0] cfg_read_data,
    output logic cfg_read_valid,
    output logic signed [pid_pkg::data_width-1:0] kp,
    output logic signed [pid_pkg::data_width-1:0] ki,
    output logic [pid_pkg::shift_width-1:0] kp_shift,
    output logic [pid_pkg::shift_width-1:0] ki_shift,
    output logic signed [pid_pkg::data_width-1:0] out_up,
    output logic signed [pid_pkg::data_width-1:0] out_down,
    output logic signed [pid_pkg::data_width-1:0] int_up,
    output logic signed [pid_pkg::data_width-1:0] int_down,
    output logic free_running
);

    import pid_pkg::*;

    pid_cfg_word_u cfg_words [cfg_word_count];

    // Writes land at the edge that carries the strobe
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < cfg_word_count; i++) begin
                cfg_words[i].raw <= cfg_reset_values[i];
            end
        end else if (cfg_write) begin
            cfg_words[cfg_write_addr].raw <= cfg_write_data;
        end
    end

    // Registered read-back, one cycle after the request
    always_ff @(posedge clock) begin
        if (!reset) begin
            cfg_read_valid <= 1'b0;
        end else begin
            cfg_read_valid <= cfg_read;
        end
    end

    always_ff @(posedge clock) begin
        if (cfg_read) begin
            cfg_read_data <= cfg_words[cfg_read_addr].raw;
        end
    end

    // Gains and limits use the low half of their words
    assign kp = cfg_words[cfg_addr_kp].raw[data_width-1:0];
    assign ki = cfg_words[cfg_addr_ki].raw[data_width-1:0];
    assign out_up = cfg_words[cfg_addr_out_up].raw[data_width-1:0];
    assign out_down = cfg_words[cfg_addr_out_down].raw[data_width-1:0];
    assign int_up = cfg_words[cfg_addr_int_up].raw[data_width-1:0];
    assign int_down = cfg_words[cfg_addr_int_down].raw[data_width-1:0];

    // The shift word packs both path shifts
    assign kp_shift = cfg_words[cfg_addr_shifts].shifts.kp_shift;
    assign ki_shift = cfg_words[cfg_addr_shifts].shifts.ki_shift;

    assign free_running = cfg_words[cfg_addr_control].raw[control_free_running_bit];

endmodule

`default_nettype wire

/* hdl/pid_error_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_error_stage (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic signed [pid_pkg::input_width-1:0] reference_data,
    input  wire logic reference_valid,
    input  wire logic signed [pid_pkg::input_width-1:0] feedback_data,
    input  wire logic feedback_valid,
    input  wire logic out_ready,
    input  wire logic free_running,
    output logic signed [pid_pkg::data_width-1:0] error_data,
    output logic error_valid
);

    import pid_pkg::*;

    logic accept;
    logic signed [data_width-1:0] reference_ext;
    logic signed [data_width-1:0] feedback_ext;

    // A pair is taken only when both samples are present and the output
    // can take the result, unless the loop runs free
    assign accept = reference_valid && feedback_valid && (out_ready || free_running);

    // Signed assignment widens with sign extension
    assign reference_ext = reference_data;
    assign feedback_ext = feedback_data;

    always_ff @(posedge clock) begin
        if (!reset) begin
            error_valid <= 1'b0;
        end else begin
            error_valid <= accept;
        end
    end

    // The difference of two 12-bit samples always fits the 16-bit error
    always_ff @(posedge clock) begin
        if (accept) begin
            error_data <= reference_ext - feedback_ext;
        end
    end

endmodule

`default_nettype wire

/* hdl/pid_proportional_path.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_proportional_path (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic signed [pid_pkg::data_width-1:0] error_data,
    input  wire logic error_valid,
    input  wire logic signed [pid_pkg::data_width-1:0] kp,
    input  wire logic [pid_pkg::shift_width-1:0] kp_shift,
    output logic signed [pid_pkg::data_width-1:0] p_term,
    output logic p_valid
);

    import pid_pkg::*;

    logic signed [product_width-1:0] product;
    logic signed [product_width-1:0] product_shifted;
    logic signed [data_width-1:0] scaled_error;
    logic scaled_valid;

    assign product = error_data * kp;
    // Arithmetic shift keeps the sign of the product
    assign product_shifted = product >>> kp_shift;

    always_ff @(posedge clock) begin
        if (!reset) begin
            scaled_valid <= 1'b0;
            p_valid <= 1'b0;
        end else begin
            scaled_valid <= error_valid;
            p_valid <= scaled_valid;
        end
    end

    // Second stage lines the term up with the integrator update
    always_ff @(posedge clock) begin
        if (error_valid) begin
            scaled_error <= product_shifted[data_width-1:0];
        end
        if (scaled_valid) begin
            p_term <= scaled_error;
        end
    end

endmodule

`default_nettype wire

/* hdl/pid_integral_path.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_integral_path (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic signed [pid_pkg::data_width-1:0] error_data,
    input  wire logic error_valid,
    input  wire logic signed [pid_pkg::data_width-1:0] ki,
    input  wire logic [pid_pkg::shift_width-1:0] ki_shift,
    input  wire logic signed [pid_pkg::data_width-1:0] int_up,
    input  wire logic signed [pid_pkg::data_width-1:0] int_down,
    output logic signed [pid_pkg::data_width-1:0] i_term,
    output logic i_valid
);

    import pid_pkg::*;

    logic signed [product_width-1:0] product;
    logic signed [product_width-1:0] product_shifted;
    logic signed [data_width-1:0] scaled_error;
    logic scaled_valid;
    logic signed [data_width-1:0] integrator;
    logic signed [sum_width-1:0] integrator_sum;
    logic signed [data_width-1:0] integrator_next;

    // Same scaling as the proportional path, with its own gain and shift
    assign product = error_data * ki;
    assign product_shifted = product >>> ki_shift;

    always_ff @(posedge clock) begin
        if (error_valid) begin
            scaled_error <= product_shifted[data_width-1:0];
        end
    end

    // The guard bit keeps the sum exact before it is clamped
    assign integrator_sum = integrator + scaled_error;

    always_comb begin
        if (integrator_sum > int_up) begin
            integrator_next = int_up;
        end else if (integrator_sum < int_down) begin
            integrator_next = int_down;
        end else begin
            integrator_next = integrator_sum[data_width-1:0];
        end
    end

    // Every scaled sample is absorbed, whether or not its output is taken
    always_ff @(posedge clock) begin
        if (!reset) begin
            scaled_valid <= 1'b0;
            i_valid <= 1'b0;
            integrator <= '0;
        end else begin
            scaled_valid <= error_valid;
            i_valid <= scaled_valid;
            if (scaled_valid) begin
                integrator <= integrator_next;
            end
        end
    end

    assign i_term = integrator;

endmodule

`default_nettype wire

/* hdl/pid_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_output_stage (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic signed [pid_pkg::data_width-1:0] p_term,
    input  wire logic signed [pid_pkg::data_width-1:0] i_term,
    input  wire logic p_valid,
    input  wire logic out_ready,
    input  wire logic signed [pid_pkg::data_width-1:0] out_up,
    input  wire logic signed [pid_pkg::data_width-1:0] out_down,
    output logic signed [pid_pkg::data_width-1:0] out_data,
    output logic out_valid
);

    import pid_pkg::*;

    logic signed [sum_width-1:0] term_sum;
    logic signed [data_width-1:0] clamped_sum;
    logic take_result;

    assign term_sum = p_term + i_term;

    always_comb begin
        if (term_sum > out_up) begin
            clamped_sum = out_up;
        end else if (term_sum < out_down) begin
            clamped_sum = out_down;
        end else begin
            clamped_sum = term_sum[data_width-1:0];
        end
    end

    // Results that meet a low ready are lost here
    assign take_result = p_valid && out_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take_result;
        end
    end

    always_ff @(posedge clock) begin
        if (take_result) begin
            out_data <= clamped_sum;
        end
    end

endmodule

`default_nettype wire

/* hdl/pid_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_controller (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic signed [pid_pkg::input_width-1:0] reference_data,
    input  wire logic reference_valid,
    input  wire logic signed [pid_pkg::input_width-1:0] feedback_data,
    input  wire logic feedback_valid,
    output logic signed [pid_pkg::data_width-1:0] out_data,
    output logic out_valid,
    input  wire logic out_ready,
    output logic signed [pid_pkg::data_width-1:0] error_data,
    output logic error_valid,
    input  wire logic cfg_write,
    input  wire logic [pid_pkg::cfg_addr_width-1:0] cfg_write_addr,
    input  wire logic [pid_pkg::cfg_word_width-1:0] cfg_write_data,
    input  wire logic cfg_read,
    input  wire logic [pid_pkg::cfg_addr_width-1:0] cfg_read_addr,
    output logic [pid_pkg::cfg_word_width-1:0] cfg_read_data,
    output logic cfg_read_valid
);

    import pid_pkg::*;

    // Configuration fields
    logic signed [data_width-1:0] kp;
    logic signed [data_width-1:0] ki;
    logic [shift_width-1:0] kp_shift;
    logic [shift_width-1:0] ki_shift;
    logic signed [data_width-1:0] out_up;
    logic signed [data_width-1:0] out_down;
    logic signed [data_width-1:0] int_up;
    logic signed [data_width-1:0] int_down;
    logic free_running;

    // Path results
    logic signed [data_width-1:0] p_term;
    logic p_valid;
    logic signed [data_width-1:0] i_term;
    logic i_valid;

    pid_config_regs config0 (
        .clock(clock),
        .reset(reset),
        .cfg_write(cfg_write),
        .cfg_write_addr(cfg_write_addr),
        .cfg_write_data(cfg_write_data),
        .cfg_read(cfg_read),
        .cfg_read_addr(cfg_read_addr),
        .cfg_read_data(cfg_read_data),
        .cfg_read_valid(cfg_read_valid),
        .kp(kp),
        .ki(ki),
        .kp_shift(kp_shift),
        .ki_shift(ki_shift),
        .out_up(out_up),
        .out_down(out_down),
        .int_up(int_up),
        .int_down(int_down),
        .free_running(free_running)
    );

    pid_error_stage error0 (
        .clock(clock),
        .reset(reset),
        .reference_data(reference_data),
        .reference_valid(reference_valid),
        .feedback_data(feedback_data),
        .feedback_valid(feedback_valid),
        .out_ready(out_ready),
        .free_running(free_running),
        .error_data(error_data),
        .error_valid(error_valid)
    );

    pid_proportional_path prop0 (
        .clock(clock),
        .reset(reset),
        .error_data(error_data),
        .error_valid(error_valid),
        .kp(kp),
        .kp_shift(kp_shift),
        .p_term(p_term),
        .p_valid(p_valid)
    );

    // i_valid marks the integrator update and moves in step with p_valid
    pid_integral_path integ0 (
        .clock(clock),
        .reset(reset),
        .error_data(error_data),
        .error_valid(error_valid),
        .ki(ki),
        .ki_shift(ki_shift),
        .int_up(int_up),
        .int_down(int_down),
        .i_term(i_term),
        .i_valid(i_valid)
    );

    pid_output_stage output0 (
        .clock(clock),
        .reset(reset),
        .p_term(p_term),
        .i_term(i_term),
        .p_valid(p_valid),
        .out_ready(out_ready),
        .out_up(out_up),
        .out_down(out_down),
        .out_data(out_data),
        .out_valid(out_valid)
    );

endmodule

`default_nettype wire

/* sim/pid_controller_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_controller_chk (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic reference_valid,
    input  wire logic feedback_valid,
    input  wire logic out_ready,
    input  wire logic free_running,
    input  wire logic error_valid,
    input  wire logic i_valid,
    input  wire logic out_valid,
    input  wire logic signed [pid_pkg::data_width-1:0] out_data,
    input  wire logic signed [pid_pkg::data_width-1:0] out_up,
    input  wire logic signed [pid_pkg::data_width-1:0] out_down
);

    int unsigned failure_count = 0;
    logic accepted;

    assign accepted = reference_valid && feedback_valid && (out_ready || free_running);

    // The error strobe is the accepted pair one register later
    error_follows_accept: assert property (
        @(posedge clock) disable iff (!reset) error_valid == $past(accepted)
    ) else begin
        failure_count++;
        $error("error_valid does not follow the accepted pair by one cycle");
    end

    // The integrator absorbs each sample two cycles after its error
    integrator_follows_error: assert property (
        @(posedge clock) disable iff (!reset) i_valid == $past(error_valid, 2)
    ) else begin
        failure_count++;
        $error("i_valid does not follow error_valid by two cycles");
    end

    // Three stages behind the error, gated by ready at the output register
    output_follows_error: assert property (
        @(posedge clock) disable iff (!reset)
            out_valid == ($past(error_valid, 3) && $past(out_ready))
    ) else begin
        failure_count++;
        $error("out_valid does not follow error_valid by three cycles");
    end

    output_within_limits: assert property (
        @(posedge clock) disable iff (!reset)
            out_valid |-> (out_data <= out_up) && (out_data >= out_down)
    ) else begin
        failure_count++;
        $error("out_data lies outside the output limits");
    end

endmodule

bind pid_controller pid_controller_chk chk0 (
    .clock(clock),
    .reset(reset),
    .reference_valid(reference_valid),
    .feedback_valid(feedback_valid),
    .out_ready(out_ready),
    .free_running(free_running),
    .error_valid(error_valid),
    .i_valid(i_valid),
    .out_valid(out_valid),
    .out_data(out_data),
    .out_up(out_up),
    .out_down(out_down)
);

`default_nettype wire

/* sim/pid_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_controller_tb;

    import pid_pkg::*;

    localparam int reset_cycles = 16;
    // Budget per test phase, six phases in all
    localparam int phase_cycles = 60;
    localparam int cycle_limit = reset_cycles + 6 * phase_cycles + 200;

    logic clock = 1'b0;
    logic reset = 1'b0;
    logic signed [input_width-1:0] reference_data = '0;
    logic reference_valid = 1'b0;
    logic signed [input_width-1:0] feedback_data = '0;
    logic feedback_valid = 1'b0;
    logic out_ready = 1'b0;
    logic cfg_write = 1'b0;
    logic [cfg_addr_width-1:0] cfg_write_addr = '0;
    logic [cfg_word_width-1:0] cfg_write_data = '0;
    logic cfg_read = 1'b0;
    logic [cfg_addr_width-1:0] cfg_read_addr = '0;
    logic signed [data_width-1:0] out_data;
    logic out_valid;
    logic signed [data_width-1:0] error_data;
    logic error_valid;
    logic [cfg_word_width-1:0] cfg_read_data;
    logic cfg_read_valid;

    integer seed = 32'h70ef;
    int cycle = 0;
    logic ready_at_edge = 1'b0;
    int error_count = 0;
    int model_integrator = 0;

    // Register contents by address, starting from the documented reset values
    logic [cfg_word_width-1:0] cfg_model [8] = '{
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_7fff,
        32'hffff_8001, 32'h0000_7fff, 32'hffff_8001, 32'h0000_0101
    };

    // Expected responses with the cycle at which each is due
    int err_due [$];
    logic [data_width-1:0] err_expected [$];
    int out_due [$];
    logic [data_width-1:0] out_expected [$];
    int read_due [$];
    logic [cfg_word_width-1:0] read_expected [$];

    pid_controller dut0 (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle = cycle + 1;
        ready_at_edge = out_ready;
    end

    function automatic int scale_error(input int err, input logic [15:0] gain,
                                       input logic [7:0] shift);
        longint product;
        product = longint'(err) * longint'($signed(gain));
        product = product >>> shift;
        return int'($signed(product[15:0]));
    endfunction

    function automatic int clamp(input int value, input int low, input int high);
        if (value > high) begin
            return high;
        end else if (value < low) begin
            return low;
        end
        return value;
    endfunction

    function automatic int limit(input logic [cfg_addr_width-1:0] addr);
        return int'($signed(cfg_model[addr][15:0]));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED %s: got %h expected %h at cycle %0d", name, got, expected, cycle);
        error_count++;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic write_reg(input logic [cfg_addr_width-1:0] addr, input logic [31:0] data);
        cfg_write = 1'b1;
        cfg_write_addr = addr;
        cfg_write_data = data;
        cfg_model[addr] = data;
        next_cycle();
        cfg_write = 1'b0;
    endtask

    task automatic read_reg(input logic [cfg_addr_width-1:0] addr);
        cfg_read = 1'b1;
        cfg_read_addr = addr;
        read_due.push_back(cycle + 1);
        read_expected.push_back(cfg_model[addr]);
        next_cycle();
        cfg_read = 1'b0;
    endtask

    // A positive direction forces a positive error, a negative one a negative error
    task automatic offer_pair(input logic ready, input int direction);
        pid_cfg_word_u shift_word;
        int err;
        int p_scaled;
        int i_scaled;
        reference_data = input_width'($random(seed));
        feedback_data = input_width'($random(seed));
        if (direction > 0) begin
            reference_data[input_width-1] = 1'b0;
            feedback_data[input_width-1] = 1'b1;
        end else if (direction < 0) begin
            reference_data[input_width-1] = 1'b1;
            feedback_data[input_width-1] = 1'b0;
        end
        reference_valid = 1'b1;
        feedback_valid = 1'b1;
        out_ready = ready;
        if (ready || cfg_model[cfg_addr_control][0]) begin
            err = int'(reference_data) - int'(feedback_data);
            shift_word = cfg_model[cfg_addr_shifts];
            p_scaled = scale_error(err, cfg_model[cfg_addr_kp][15:0], shift_word.shifts.kp_shift);
            i_scaled = scale_error(err, cfg_model[cfg_addr_ki][15:0], shift_word.shifts.ki_shift);
            model_integrator = clamp(model_integrator + i_scaled, limit(cfg_addr_int_down),
                                     limit(cfg_addr_int_up));
            err_due.push_back(cycle + 1);
            err_expected.push_back(data_width'(err));
            out_due.push_back(cycle + 4);
            out_expected.push_back(data_width'(clamp(p_scaled + model_integrator,
                                   limit(cfg_addr_out_down), limit(cfg_addr_out_up))));
        end
        next_cycle();
        reference_valid = 1'b0;
        feedback_valid = 1'b0;
    endtask

    task automatic drain();
        while (err_due.size() > 0 || out_due.size() > 0 || read_due.size() > 0) begin
            next_cycle();
        end
    endtask

    task automatic check_outputs();
        logic [data_width-1:0] expected_data;
        logic [cfg_word_width-1:0] expected_word;
        if (err_due.size() > 0 && err_due[0] == cycle) begin
            void'(err_due.pop_front());
            expected_data = err_expected.pop_front();
            assert (error_valid === 1'b1) else report_mismatch("error_valid", error_valid, 1);
            assert (error_data === expected_data)
                else report_mismatch("error_data", error_data, expected_data);
        end else begin
            assert (error_valid === 1'b0) else report_mismatch("error_valid", error_valid, 0);
        end
        // A result meeting a low ready at the output register is dropped
        if (out_due.size() > 0 && out_due[0] == cycle) begin
            void'(out_due.pop_front());
            expected_data = out_expected.pop_front();
            assert (out_valid === ready_at_edge)
                else report_mismatch("out_valid", out_valid, ready_at_edge);
            if (ready_at_edge) begin
                assert (out_data === expected_data)
                    else report_mismatch("out_data", out_data, expected_data);
            end
        end else begin
            assert (out_valid === 1'b0) else report_mismatch("out_valid", out_valid, 0);
        end
        if (read_due.size() > 0 && read_due[0] == cycle) begin
            void'(read_due.pop_front());
            expected_word = read_expected.pop_front();
            assert (cfg_read_valid === 1'b1)
                else report_mismatch("cfg_read_valid", cfg_read_valid, 1);
            assert (cfg_read_data === expected_word)
                else report_mismatch("cfg_read_data", cfg_read_data, expected_word);
        end else begin
            assert (cfg_read_valid === 1'b0)
                else report_mismatch("cfg_read_valid", cfg_read_valid, 0);
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            check_outputs();
        end
    end

    initial begin
        wait (cycle >= cycle_limit);
        $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        pid_cfg_word_u shift_word;
        repeat (reset_cycles) @(posedge clock);
        #0.5;
        reset = 1'b1;
        next_cycle();

        // Reset values first, then random words read back
        for (int a = 0; a < 8; a++) read_reg(a);
        for (int a = 0; a < 8; a++) write_reg(a, $random(seed));
        for (int a = 0; a < 8; a++) read_reg(a);
        drain();

        // Proportional path alone, with output limits inside the scaled range
        write_reg(cfg_addr_control, 32'd0);
        write_reg(cfg_addr_ki, 32'd0);
        write_reg(cfg_addr_kp, 32'd24);
        shift_word = '0;
        shift_word.shifts.kp_shift = 8'd2;
        shift_word.shifts.ki_shift = 8'd4;
        write_reg(cfg_addr_shifts, shift_word.raw);
        write_reg(cfg_addr_int_up, 32'd32767);
        write_reg(cfg_addr_int_down, -32'sd32767);
        write_reg(cfg_addr_out_up, 32'd20000);
        write_reg(cfg_addr_out_down, -32'sd20000);
        for (int i = 0; i < 40; i++) offer_pair(1'b1, 0);
        drain();

        // Integral path alone, pushed into both clamps in each direction
        write_reg(cfg_addr_kp, 32'd0);
        write_reg(cfg_addr_ki, 32'd16);
        write_reg(cfg_addr_int_up, 32'd3000);
        write_reg(cfg_addr_int_down, -32'sd3000);
        write_reg(cfg_addr_out_up, 32'd2000);
        write_reg(cfg_addr_out_down, -32'sd2500);
        for (int i = 0; i < 36; i++) offer_pair(1'b1, (i < 12) ? 1 : ((i < 24) ? -1 : 0));
        drain();

        // Blocking mode with ready low, then the next visible output
        write_reg(cfg_addr_ki, 32'd8);
        write_reg(cfg_addr_int_up, 32'd30000);
        write_reg(cfg_addr_int_down, -32'sd30000);
        write_reg(cfg_addr_out_up, 32'd32767);
        write_reg(cfg_addr_out_down, -32'sd32767);
        for (int i = 0; i < 4; i++) offer_pair(1'b1, 0);
        for (int i = 0; i < 8; i++) offer_pair(1'b0, 0);
        for (int i = 0; i < 2; i++) offer_pair(1'b1, 0);
        drain();

        // Free-running mode integrates pairs whose outputs are lost
        write_reg(cfg_addr_control, 32'd1);
        for (int i = 0; i < 8; i++) offer_pair(1'b0, 0);
        for (int i = 0; i < 4; i++) offer_pair(1'b1, 0);
        drain();
        next_cycle();

        $display("Errors: %0d from model checks, %0d from bound assertions",
                 error_count, dut0.chk0.failure_count);
        if (error_count == 0 && dut0.chk0.failure_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/pid_pkg.sv
hdl/pid_config_regs.sv
hdl/pid_error_stage.sv
hdl/pid_proportional_path.sv
hdl/pid_integral_path.sv
hdl/pid_output_stage.sv
hdl/pid_controller.sv
sim/pid_controller_chk.sv
sim/pid_controller_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PI controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module pid_controller_tb -Mdir obj_dir -f build.f

output=$(./obj_dir/Vpid_controller_tb +verilator+error+limit+1000)
echo "$output"

if grep -q "^TESTS PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi
